/* source/cache_pkg.sv */
/*
  Geometry of the instruction cache and the vector types built on it
  Sizes must stay powers of two so the index and offset fields split cleanly
*/
package cache_pkg;

  // ==============================
  // Cache geometry
  // ==============================

  // Byte address width seen by the requester and by memory
  localparam int ADDR_W      = 32;
  // One cache line in bits
  localparam int BLK_W       = 128;
  // Associativity
  localparam int NUM_WAY     = 4;
  // Total capacity in bytes
  localparam int CACHE_BYTES = 512;

  // Derived sizes
  localparam int NUM_SET = CACHE_BYTES / (BLK_W / 8) / NUM_WAY;
  localparam int IDX_W   = $clog2(NUM_SET);
  localparam int BOFF_W  = $clog2(BLK_W / 8);
  localparam int TAG_W   = ADDR_W - IDX_W - BOFF_W;
  // Depth of the PLRU tree and width of a way number
  localparam int WAY_W   = $clog2(NUM_WAY);

  // ==============================
  // Vector types
  // ==============================

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [IDX_W-1:0]   idx_t;
  typedef logic [BLK_W-1:0]   blk_t;
  // One bit per way, used one-hot for hits, victims and writes
  typedef logic [NUM_WAY-1:0] way_vec_t;
  // Heap-ordered tree nodes, node 0 is the root
  typedef logic [NUM_WAY-2:0] node_t;

endpackage

/* source/tag_data_store.sv */
/*
  Tag, valid and data arrays with a registered read every cycle
  No reset, contents are only meaningful after a flush walk
*/
module tag_data_store import cache_pkg::*; (
  input  logic               clk_i,
  input  idx_t               rd_idx_i,
  input  logic               wr_en_i,
  input  idx_t               wr_idx_i,
  input  way_vec_t           wr_way_i,
  input  tag_t               wr_tag_i,
  input  logic               wr_valid_i,
  input  blk_t               wr_blk_i,
  output tag_t [NUM_WAY-1:0] rd_tag_o,
  output way_vec_t           rd_valid_o,
  output blk_t [NUM_WAY-1:0] rd_blk_o
);

  // Valid bit sits on top of the tag
  logic [TAG_W:0] tag_mem  [NUM_WAY][NUM_SET];
  blk_t           data_mem [NUM_WAY][NUM_SET];

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAY; w++) begin
      // Shared write port, every selected way takes the same entry
      if (wr_en_i && wr_way_i[w]) begin
        tag_mem[w][wr_idx_i] <= {wr_valid_i, wr_tag_i};
        // Invalidation leaves the data untouched
        if (wr_valid_i) begin
          data_mem[w][wr_idx_i] <= wr_blk_i;
        end
      end
      // Read returns the old entry on a same-index write
      rd_valid_o[w] <= tag_mem[w][rd_idx_i][TAG_W];
      rd_tag_o[w]   <= tag_mem[w][rd_idx_i][TAG_W-1:0];
      rd_blk_o[w]   <= data_mem[w][rd_idx_i];
    end
  end

endmodule

/* source/plru_policy.sv */
/*
  Tree pseudo-LRU per set, node state held in flops
  Victim is combinational from the addressed set and its valid bits
*/
module plru_policy import cache_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  idx_t     idx_i,
  input  way_vec_t valid_i,
  input  logic     touch_i,
  input  way_vec_t touch_way_i,
  input  logic     clear_i,
  output way_vec_t victim_o
);

  node_t node_q [NUM_SET];
  node_t node_nxt;

  // One-hot way vector to way number
  function automatic logic [WAY_W-1:0] way_num(input way_vec_t onehot);
    logic [WAY_W-1:0] num;
    num = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (onehot[w]) begin
        num = WAY_W'(w);
      end
    end
    return num;
  endfunction

  // ==============================
  // Victim choice
  // ==============================
  always_comb begin
    node_t            cur;
    int unsigned      n;
    logic [WAY_W-1:0] pick;
    logic             found;
    cur  = node_q[idx_i];
    pick = '0;
    n    = 0;
    // Walk from the root, a set bit points to the upper half
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      pick[WAY_W-1-lvl] = cur[n];
      n = 2 * n + 1 + 32'(cur[n]);
    end
    victim_o       = '0;
    victim_o[pick] = 1'b1;
    // Lowest empty way wins over the tree
    found = 1'b0;
    for (int w = 0; w < NUM_WAY; w++) begin
      if (!found && !valid_i[w]) begin
        victim_o    = '0;
        victim_o[w] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  // ==============================
  // Update on access
  // ==============================
  always_comb begin
    int unsigned      n;
    logic [WAY_W-1:0] tw;
    tw       = way_num(touch_way_i);
    node_nxt = node_q[idx_i];
    n        = 0;
    // Every node on the path points away from the touched way
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      node_nxt[n] = !tw[WAY_W-1-lvl];
      n = 2 * n + 1 + 32'(tw[WAY_W-1-lvl]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        node_q[s] <= '0;
      end
    end else if (clear_i) begin
      node_q[idx_i] <= '0;
    end else if (touch_i) begin
      node_q[idx_i] <= node_nxt;
    end
  end

endmodule

/* source/icache_ctrl.sv */
/*
  Cache controller with flush walk, one-cycle lookup and single refill
  Flush is taken only when no request is held, at most one miss outstanding
*/
module icache_ctrl import cache_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Requester side
  input  logic               req_valid_i,
  input  addr_t              req_addr_i,
  output logic               req_ready_o,
  output logic               rsp_valid_o,
  output blk_t               rsp_blk_o,
  input  logic               flush_i,
  // Lower memory side
  output logic               mem_req_valid_o,
  output addr_t              mem_req_addr_o,
  input  logic               mem_req_ready_i,
  input  logic               mem_rsp_valid_i,
  input  blk_t               mem_rsp_blk_i,
  // Array read
  output idx_t               rd_idx_o,
  input  tag_t [NUM_WAY-1:0] rd_tag_i,
  input  way_vec_t           rd_valid_i,
  input  blk_t [NUM_WAY-1:0] rd_blk_i,
  // Array write
  output logic               wr_en_o,
  output idx_t               wr_idx_o,
  output way_vec_t           wr_way_o,
  output tag_t               wr_tag_o,
  output logic               wr_valid_o,
  output blk_t               wr_blk_o,
  // Replacement policy
  output logic               touch_o,
  output way_vec_t           touch_way_o,
  output logic               clear_o,
  output idx_t               plru_idx_o,
  input  way_vec_t           victim_i
);

  // FLUSH must be the zero encoding, it is the state out of reset
  typedef enum logic [1:0] {
    FLUSH  = 2'd0,
    RUN    = 2'd1,
    REFILL = 2'd2
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;
  idx_t        flush_idx_q;
  logic        req_vld_q;
  addr_t       req_addr_q;
  way_vec_t    victim_q;
  logic        sent_q;
  logic        rsp_valid_q;
  blk_t        rsp_blk_q;

  tag_t     req_tag;
  idx_t     req_idx;
  way_vec_t hit_vec;
  blk_t     hit_blk;
  logic     lookup, hit, miss;
  logic     flush_go, refill_done, accept;

  assign req_tag = req_addr_q[ADDR_W-1 -: TAG_W];
  assign req_idx = req_addr_q[BOFF_W +: IDX_W];

  // ==============================
  // Lookup
  // ==============================
  // Arrays read the incoming index each cycle, so data lines up with the held request
  assign rd_idx_o = req_addr_i[BOFF_W +: IDX_W];

  always_comb begin
    hit_blk = '0;
    for (int w = 0; w < NUM_WAY; w++) begin
      hit_vec[w] = rd_valid_i[w] && (rd_tag_i[w] == req_tag);
      if (hit_vec[w]) begin
        hit_blk = rd_blk_i[w];
      end
    end
  end

  assign lookup      = (state_q == RUN) && req_vld_q;
  assign hit         = lookup && (|hit_vec);
  assign miss        = lookup && !(|hit_vec);
  assign flush_go    = (state_q == RUN) && !req_vld_q && flush_i;
  assign refill_done = (state_q == REFILL) && mem_rsp_valid_i;

  // Ready drops combinationally in the cycle a miss is seen
  assign req_ready_o = (state_q == RUN) && !miss && !flush_go;
  assign accept      = req_valid_i && req_ready_o;

  // ==============================
  // State machine
  // ==============================
  always_comb begin
    state_d = state_q;
    case (state_q)
      FLUSH:   if (flush_idx_q == IDX_W'(NUM_SET - 1)) state_d = RUN;
      RUN: begin
        if (miss) begin
          state_d = REFILL;
        end else if (flush_go) begin
          state_d = FLUSH;
        end
      end
      REFILL:  if (mem_rsp_valid_i) state_d = RUN;
      default: state_d = FLUSH;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      flush_idx_q <= '0;
      req_vld_q   <= 1'b0;
      sent_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= hit;
      // Wraps back to zero after the last set
      if (state_q == FLUSH) begin
        flush_idx_q <= flush_idx_q + 1'b1;
      end
      // Held request stays through the refill
      if (refill_done) begin
        req_vld_q <= 1'b0;
      end else if ((state_q == RUN) && !miss) begin
        req_vld_q <= accept;
      end
      if (refill_done) begin
        sent_q <= 1'b0;
      end else if (mem_req_valid_o && mem_req_ready_i) begin
        sent_q <= 1'b1;
      end
    end
  end

  // Request, victim and hit data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= req_addr_i;
    end
    if (miss) begin
      victim_q <= victim_i;
    end
    rsp_blk_q <= hit_blk;
  end

  // ==============================
  // Memory and response
  // ==============================
  assign mem_req_valid_o = miss || ((state_q == REFILL) && !sent_q);
  assign mem_req_addr_o  = {req_addr_q[ADDR_W-1:BOFF_W], {BOFF_W{1'b0}}};

  // Refilled line goes out in the same cycle it is written
  assign rsp_valid_o = rsp_valid_q || refill_done;
  assign rsp_blk_o   = refill_done ? mem_rsp_blk_i : rsp_blk_q;

  // Flush clears all ways of one set per cycle
  assign wr_en_o    = (state_q == FLUSH) || refill_done;
  assign wr_idx_o   = (state_q == FLUSH) ? flush_idx_q : req_idx;
  assign wr_way_o   = (state_q == FLUSH) ? '1 : victim_q;
  assign wr_tag_o   = req_tag;
  assign wr_valid_o = (state_q != FLUSH);
  assign wr_blk_o   = mem_rsp_blk_i;

  assign touch_o     = hit || refill_done;
  assign touch_way_o = hit ? hit_vec : victim_q;
  assign clear_o     = (state_q == FLUSH);
  assign plru_idx_o  = (state_q == FLUSH) ? flush_idx_q : req_idx;

endmodule

/* source/icache_top.sv */
/*
  Read-only instruction cache, one request in lookup at a time
  Not usable until the flush walk after reset has finished
*/
module icache_top import cache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Requester side
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  output logic  req_ready_o,
  output logic  rsp_valid_o,
  output blk_t  rsp_blk_o,
  input  logic  flush_i,
  // Lower memory side
  output logic  mem_req_valid_o,
  output addr_t mem_req_addr_o,
  input  logic  mem_req_ready_i,
  input  logic  mem_rsp_valid_i,
  input  blk_t  mem_rsp_blk_i
);

  // Array read path
  idx_t                 rd_idx;
  tag_t [NUM_WAY-1:0]   rd_tag;
  way_vec_t             rd_valid;
  blk_t [NUM_WAY-1:0]   rd_blk;

  // Array write path
  logic     wr_en;
  idx_t     wr_idx;
  way_vec_t wr_way;
  tag_t     wr_tag;
  logic     wr_valid;
  blk_t     wr_blk;

  // Replacement policy
  logic     touch;
  way_vec_t touch_way;
  logic     clear;
  idx_t     plru_idx;
  way_vec_t victim;

  icache_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_blk_o       (rsp_blk_o),
    .flush_i         (flush_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_blk_i   (mem_rsp_blk_i),
    .rd_idx_o        (rd_idx),
    .rd_tag_i        (rd_tag),
    .rd_valid_i      (rd_valid),
    .rd_blk_i        (rd_blk),
    .wr_en_o         (wr_en),
    .wr_idx_o        (wr_idx),
    .wr_way_o        (wr_way),
    .wr_tag_o        (wr_tag),
    .wr_valid_o      (wr_valid),
    .wr_blk_o        (wr_blk),
    .touch_o         (touch),
    .touch_way_o     (touch_way),
    .clear_o         (clear),
    .plru_idx_o      (plru_idx),
    .victim_i        (victim)
  );

  tag_data_store u_store (
    .clk_i      (clk_i),
    .rd_idx_i   (rd_idx),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_way_i   (wr_way),
    .wr_tag_i   (wr_tag),
    .wr_valid_i (wr_valid),
    .wr_blk_i   (wr_blk),
    .rd_tag_o   (rd_tag),
    .rd_valid_o (rd_valid),
    .rd_blk_o   (rd_blk)
  );

  // Valid bits go straight from the store so the policy can prefer an empty way
  plru_policy u_plru (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .idx_i       (plru_idx),
    .valid_i     (rd_valid),
    .touch_i     (touch),
    .touch_way_i (touch_way),
    .clear_i     (clear),
    .victim_o    (victim)
  );

endmodule

/* test/icache_assert.sv */
/*
  Concurrent checks on the cache handshakes, bound into the top level
  Assumes flush pulses only arrive while the cache is idle
*/
module icache_assert import cache_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  flush_i,
  input logic  req_valid_i,
  input logic  req_ready_o,
  input logic  rsp_valid_o,
  input logic  mem_req_valid_o,
  input logic  mem_req_ready_i,
  input addr_t mem_req_addr_o
);

  // Accepted requests still waiting for a response
  int unsigned pending;
  // Cycles of the flush walk still to come
  int unsigned flush_left;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending    <= 0;
      flush_left <= 0;
    end else begin
      pending <= pending + 32'(req_valid_i && req_ready_o) - 32'(rsp_valid_o);
      if (flush_i) begin
        flush_left <= 8;
      end else if (flush_left != 0) begin
        flush_left <= flush_left - 1;
      end
    end
  end

  mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o))
    else $error("memory request dropped or changed before ready");

  rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> pending != 0)
    else $error("response without an accepted request");

  flush_blocks_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (flush_i || flush_left != 0) |-> !req_ready_o)
    else $error("request ready high during a flush walk");

endmodule

bind icache_top icache_assert u_assert (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .flush_i         (flush_i),
  .req_valid_i     (req_valid_i),
  .req_ready_o     (req_ready_o),
  .rsp_valid_o     (rsp_valid_o),
  .mem_req_valid_o (mem_req_valid_o),
  .mem_req_ready_i (mem_req_ready_i),
  .mem_req_addr_o  (mem_req_addr_o)
);

/* test/tb_icache.sv */
/*
  Testbench for the instruction cache, with a memory model and a reference model
  Expects the 4-way tree layout, flush pulses are only sent while idle
*/
module tb_icache import cache_pkg::*; ();

  localparam int          CYCLE_LIMIT = 2000;
  localparam int          RAND_REQS   = 120;
  localparam logic [15:0] SEED        = 16'd77;
  // Five lines of set 0 for the replacement sequence
  localparam addr_t LINE_A = 32'h0000_1000;
  localparam addr_t LINE_B = 32'h0000_2000;
  localparam addr_t LINE_C = 32'h0000_3000;
  localparam addr_t LINE_D = 32'h0000_4000;
  localparam addr_t LINE_E = 32'h0000_5000;

  logic  clk_i, rst_ni, flush_i;
  logic  req_valid_i, req_ready_o, rsp_valid_o;
  addr_t req_addr_i, mem_req_addr_o;
  blk_t  rsp_blk_o, mem_rsp_blk_i;
  logic  mem_req_valid_o, mem_req_ready_i, mem_rsp_valid_i;

  // Reference tags, valid bits and tree nodes
  logic [TAG_W-1:0]   model_tag  [NUM_SET][NUM_WAY];
  logic               model_vld  [NUM_SET][NUM_WAY];
  logic [NUM_WAY-2:0] model_tree [NUM_SET];
  blk_t  exp_blk_q[$];
  addr_t exp_miss_q[$];
  addr_t last_mem_addr;
  int    errors, checks, mem_reqs, cycles;
  logic [15:0] drv_lfsr, mem_lfsr;

  icache_top u_icache_top (.*);

  // ==============================
  // Reference functions
  // ==============================
  // Line address in every word, XORed with the word number
  function automatic blk_t ref_line(addr_t a);
    blk_t  b;
    addr_t line;
    line = a & ~addr_t'(BLK_W / 8 - 1);
    for (int i = 0; i < BLK_W / ADDR_W; i++) begin
      b[i*ADDR_W +: ADDR_W] = line ^ addr_t'(i);
    end
    return b;
  endfunction

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] st, input int nbits, output int unsigned val);
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      st  = lfsr_next(st);
      val = (val << 1) | 32'(st[0]);
    end
  endtask

  task automatic model_flush();
    for (int s = 0; s < NUM_SET; s++) begin
      model_tree[s] = '0;
      for (int w = 0; w < NUM_WAY; w++) begin
        model_vld[s][w] = 1'b0;
      end
    end
  endtask

  // Predicts hit or miss, installs on a miss and updates the tree
  task automatic model_access(addr_t a);
    int               s, way, hi;
    logic [TAG_W-1:0] t;
    s   = int'(a[BOFF_W +: IDX_W]);
    t   = a[ADDR_W-1 -: TAG_W];
    way = -1;
    for (int i = 0; i < NUM_WAY; i++) begin
      if (model_vld[s][i] && model_tag[s][i] == t) way = i;
    end
    if (way < 0) begin
      exp_miss_q.push_back(a & ~addr_t'(BLK_W / 8 - 1));
      for (int i = NUM_WAY - 1; i >= 0; i--) begin
        if (!model_vld[s][i]) way = i;
      end
      // Full set, follow the root then the node of that half
      if (way < 0) begin
        hi  = int'(model_tree[s][0]);
        way = 2 * hi + int'(model_tree[s][1 + hi]);
      end
      model_vld[s][way] = 1'b1;
      model_tag[s][way] = t;
    end
    hi = way / 2;
    model_tree[s][0]      = (hi == 0);
    model_tree[s][1 + hi] = (way % 2 == 0);
    exp_blk_q.push_back(ref_line(a));
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_blk(string name, blk_t got, blk_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_miss(string name, addr_t got, addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Called just after a rising edge, returns after the transfer edge
  task automatic issue(input addr_t a, output int stalls);
    stalls = 0;
    req_valid_i <= 1'b1;
    req_addr_i  <= a;
    @(negedge clk_i);
    while (!req_ready_o) begin
      stalls++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    model_access(a);
  endtask

  task automatic drain();
    req_valid_i <= 1'b0;
    while (exp_blk_q.size() != 0) @(posedge clk_i);
  endtask

  // ==============================
  // Clock, timeout, checkers
  // ==============================
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      errors++;
      $display("Timeout after %0d cycles, the cache stopped responding", cycles);
      finish_run();
    end
  end

  // Responses in order
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_ni && rsp_valid_o) begin
        if (exp_blk_q.size() == 0) begin
          errors++;
          $display("Response seen with no request outstanding");
        end else begin
          check_blk("rsp_blk_o", rsp_blk_o, exp_blk_q.pop_front());
        end
      end
    end
  end

  // Memory model with random ready and response delays
  initial begin
    addr_t       a;
    int unsigned dly;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_valid_o) begin
        a = mem_req_addr_o;
        draw_bits(mem_lfsr, 2, dly);
        repeat (dly) @(negedge clk_i);
        @(posedge clk_i);
        mem_req_ready_i <= 1'b1;
        @(negedge clk_i);
        @(posedge clk_i);
        mem_req_ready_i <= 1'b0;
        mem_reqs++;
        last_mem_addr = a;
        if (exp_miss_q.size() == 0) begin
          errors++;
          $display("Memory request for %h where a hit was expected", a);
        end else begin
          check_miss("mem_req_addr_o", a, exp_miss_q.pop_front());
        end
        draw_bits(mem_lfsr, 2, dly);
        repeat (dly) @(posedge clk_i);
        mem_rsp_valid_i <= 1'b1;
        mem_rsp_blk_i   <= ref_line(a);
        @(posedge clk_i);
        mem_rsp_valid_i <= 1'b0;
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    int          st, total, base;
    int unsigned r_tag, r_set, r_off;
    rst_ni          <= 1'b0;
    flush_i         <= 1'b0;
    req_valid_i     <= 1'b0;
    req_addr_i      <= '0;
    mem_req_ready_i <= 1'b0;
    mem_rsp_valid_i <= 1'b0;
    mem_rsp_blk_i   <= '0;
    errors   = 0;
    checks   = 0;
    mem_reqs = 0;
    cycles   = 0;
    drv_lfsr = SEED;
    mem_lfsr = SEED;
    model_flush();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Flush walk keeps ready low
    repeat (8) begin
      @(negedge clk_i);
      if (req_ready_o) begin
        errors++;
        $display("Request ready went high during the flush walk after reset");
      end
    end
    @(posedge clk_i);
    // First touch of lines in sets 1 to 7
    for (int s = 1; s < NUM_SET; s++) issue(32'h0000_8004 + addr_t'(s * 16), st);
    drain();
    check_miss("first access misses", addr_t'(mem_reqs), addr_t'(7));
    // Cached lines stream back to back
    base  = mem_reqs;
    total = 0;
    for (int k = 0; k < 2; k++) begin
      for (int s = 1; s < NUM_SET; s++) begin
        issue(32'h0000_8000 + addr_t'(s * 16 + 4 * k), st);
        total += st;
      end
    end
    drain();
    if (total != 0) begin
      errors++;
      $display("Request ready dropped %0d times during a stream of hits", total);
    end
    check_miss("hit stream misses", addr_t'(mem_reqs - base), '0);
    // Replacement order in set 0, E takes the way of C
    issue(LINE_A, st);
    issue(LINE_B, st);
    issue(LINE_C, st);
    issue(LINE_D, st);
    issue(LINE_A, st);
    issue(LINE_E, st);
    drain();
    base = mem_reqs;
    // Survivors first, then the replaced line
    issue(LINE_A, st);
    issue(LINE_B, st);
    issue(LINE_D, st);
    issue(LINE_E, st);
    issue(LINE_C, st);
    drain();
    check_miss("set 0 final round misses", addr_t'(mem_reqs - base), addr_t'(1));
    check_miss("set 0 replaced line", last_mem_addr, LINE_C);
    // Flush empties the whole cache
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    model_flush();
    base = mem_reqs;
    for (int s = 1; s < NUM_SET; s++) issue(32'h0000_8004 + addr_t'(s * 16), st);
    // Set 0 as well
    issue(LINE_E, st);
    drain();
    check_miss("misses after flush", addr_t'(mem_reqs - base), addr_t'(8));
    // Random stream over 3 tags and all sets
    for (int i = 0; i < RAND_REQS; i++) begin
      draw_bits(drv_lfsr, 2, r_tag);
      draw_bits(drv_lfsr, IDX_W, r_set);
      draw_bits(drv_lfsr, 2, r_off);
      issue(32'h0010_0000 * addr_t'(r_tag % 3 + 1) + addr_t'(r_set * 16 + r_off * 4), st);
    end
    drain();
    check_miss("memory requests versus predicted misses", addr_t'(exp_miss_q.size()), '0);
    repeat (2) @(posedge clk_i);
    finish_run();
  end

endmodule

/* icache_top.f */
source/cache_pkg.sv
source/tag_data_store.sv
source/plru_policy.sv
source/icache_ctrl.sv
source/icache_top.sv
test/icache_assert.sv
test/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_icache \
  -f icache_top.f \
  -o sim_icache

./obj_dir/sim_icache | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
